// ==== rtl/dcachePkg.sv ====
package dcachePkg;

  // address and word geometry
  localparam int ADDR_W = 32;
  localparam int XLEN = 64;

  // one line is four 64-bit words
  localparam int LINE_BYTES = 32;
  localparam int WORDS_PER_LINE = (LINE_BYTES * 8) / XLEN;
  localparam int OFFSET_W = $clog2(LINE_BYTES);

  // byte lanes in one data word
  localparam int WORD_BYTES = XLEN / 8;

  typedef logic [XLEN-1:0] word_t;

  typedef logic [LINE_BYTES*8-1:0] line_t;

  typedef logic [WORD_BYTES-1:0] mask_t;

  // controller states
  // COMPARE checks the lookup and replays a request after a refill
  typedef enum logic [2:0] {
    IDLE,
    COMPARE,
    WRITEBACK,
    REFILLREQ,
    REFILL,
    REPLACE
  } ctrlState_e;

endpackage

// ==== rtl/cacheCtrlIf.sv ====
`timescale 1ns/1ps

interface cacheCtrlIf #(
  parameter int NUM_SETS = 64
) ();

  localparam int IDX_W = $clog2(NUM_SETS);
  localparam int TAG_W = dcachePkg::ADDR_W - IDX_W - dcachePkg::OFFSET_W;

  // latched request, driven by the controller
  logic [dcachePkg::ADDR_W-1:0] reqAddr;
  logic reqWrite;
  dcachePkg::word_t wrData;
  dcachePkg::mask_t wrMask;

  // array control
  logic [IDX_W-1:0] lookupIndex;
  logic lookupEn;
  logic storeWe;
  logic fillWe;
  logic victimWay;
  logic beatEn;

  // lookup results from the tag side
  logic hit;
  logic hitWay;
  logic victimDirty;
  logic [TAG_W-1:0] victimTag;

  // line data
  dcachePkg::line_t fillLine;
  dcachePkg::word_t rdWord;
  dcachePkg::line_t victimLine;

  modport ctrl (
    output reqAddr, reqWrite, wrData, wrMask,
    output lookupIndex, lookupEn, storeWe, fillWe, victimWay, beatEn,
    input  hit, hitWay, victimDirty, victimTag
  );

  modport tag (
    input  reqAddr, lookupIndex, lookupEn, storeWe, fillWe, victimWay,
    output hit, hitWay, victimDirty, victimTag
  );

  modport data (
    input  reqAddr, reqWrite, wrData, wrMask,
    input  lookupIndex, lookupEn, storeWe, fillWe, victimWay, hitWay, fillLine,
    output rdWord, victimLine
  );

  modport refill (
    input  beatEn,
    output fillLine
  );

endinterface

// ==== rtl/cacheCtrl.sv ====
`timescale 1ns/1ps

module cacheCtrl #(
  parameter int NUM_SETS = 64
) (
  input  logic clk,
  input  logic rst_n,
  input  logic reqValid_i,
  input  logic reqWrite_i,
  input  logic [dcachePkg::ADDR_W-1:0] addr_i,
  input  dcachePkg::word_t wrData_i,
  input  dcachePkg::mask_t wrMask_i,
  output logic rdValid_o,
  output logic [dcachePkg::ADDR_W-1:0] rdAddr_o,
  input  logic rdReady_i,
  input  logic rdLast_i,
  output logic wrValid_o,
  output logic [dcachePkg::ADDR_W-1:0] wrAddr_o,
  input  logic wrReady_i,
  input  logic dataValid_i,
  output logic addrOk_o,
  output logic dataOk_o,
  cacheCtrlIf.ctrl bus
);

  localparam int IDX_W = $clog2(NUM_SETS);

  dcachePkg::ctrlState_e state;
  dcachePkg::ctrlState_e nextState;
  logic accept;
  logic inCompare;
  logic [IDX_W-1:0] reqIndex;

  assign inCompare = (state == dcachePkg::COMPARE);
  assign reqIndex = bus.reqAddr[dcachePkg::OFFSET_W +: IDX_W];

  // loads may stream behind a load hit, a store hit blocks one cycle
  assign addrOk_o = (state == dcachePkg::IDLE) || (inCompare && bus.hit && !bus.reqWrite);
  assign accept = reqValid_i && addrOk_o;
  assign dataOk_o = inCompare && bus.hit;

  always_comb begin
    nextState = state;
    case (state)
      dcachePkg::IDLE: begin
        if (accept) begin
          nextState = dcachePkg::COMPARE;
        end
      end
      dcachePkg::COMPARE: begin
        if (bus.hit) begin
          nextState = accept ? dcachePkg::COMPARE : dcachePkg::IDLE;
        end else if (bus.victimDirty) begin
          nextState = dcachePkg::WRITEBACK;
        end else begin
          nextState = dcachePkg::REFILLREQ;
        end
      end
      dcachePkg::WRITEBACK: begin
        if (wrReady_i) begin
          nextState = dcachePkg::REFILLREQ;
        end
      end
      dcachePkg::REFILLREQ: begin
        if (rdReady_i) begin
          nextState = dcachePkg::REFILL;
        end
      end
      dcachePkg::REFILL: begin
        if (dataValid_i && rdLast_i) begin
          nextState = dcachePkg::REPLACE;
        end
      end
      dcachePkg::REPLACE: begin
        nextState = dcachePkg::COMPARE;
      end
      default: begin
        nextState = dcachePkg::IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= dcachePkg::IDLE;
      bus.victimWay <= 1'b0;
    end else begin
      state <= nextState;
      // next refill goes to the other way
      if (state == dcachePkg::REPLACE) begin
        bus.victimWay <= ~bus.victimWay;
      end
    end
  end

  // request latch
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      bus.reqWrite <= 1'b0;
    end else if (accept) begin
      bus.reqWrite <= reqWrite_i;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      bus.reqAddr <= addr_i;
      bus.wrData <= wrData_i;
      bus.wrMask <= wrMask_i;
    end
  end

  // incoming index on acceptance, latched index otherwise
  assign bus.lookupIndex = accept ? addr_i[dcachePkg::OFFSET_W +: IDX_W] : reqIndex;
  assign bus.lookupEn = accept;
  assign bus.storeWe = inCompare && bus.hit && bus.reqWrite;
  assign bus.fillWe = (state == dcachePkg::REPLACE);
  assign bus.beatEn = (state == dcachePkg::REFILL);

  // memory bus requests, both line aligned
  assign wrValid_o = (state == dcachePkg::WRITEBACK);
  assign wrAddr_o = {bus.victimTag, reqIndex, {dcachePkg::OFFSET_W{1'b0}}};
  assign rdValid_o = (state == dcachePkg::REFILLREQ);
  assign rdAddr_o = {bus.reqAddr[dcachePkg::ADDR_W-1:dcachePkg::OFFSET_W],
                     {dcachePkg::OFFSET_W{1'b0}}};

endmodule

// ==== rtl/tagStore.sv ====
`timescale 1ns/1ps

module tagStore #(
  parameter int NUM_SETS = 64
) (
  input  logic clk,
  input  logic rst_n,
  cacheCtrlIf.tag bus
);

  localparam int IDX_W = $clog2(NUM_SETS);
  localparam int TAG_W = dcachePkg::ADDR_W - IDX_W - dcachePkg::OFFSET_W;

  logic [1:0][NUM_SETS-1:0] validQ;
  logic [1:0][NUM_SETS-1:0] dirtyQ;
  logic [TAG_W-1:0] tagMem [2][NUM_SETS];
  logic [IDX_W-1:0] rdIdx;
  logic [TAG_W-1:0] reqTag;
  logic [1:0] wayHit;

  assign reqTag = bus.reqAddr[dcachePkg::ADDR_W-1 -: TAG_W];

  // status bits and the registered lookup index
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      validQ <= '0;
      dirtyQ <= '0;
      rdIdx <= '0;
    end else begin
      if (bus.lookupEn) begin
        rdIdx <= bus.lookupIndex;
      end
      if (bus.fillWe) begin
        validQ[bus.victimWay][bus.lookupIndex] <= 1'b1;
        dirtyQ[bus.victimWay][bus.lookupIndex] <= 1'b0;
      end else if (bus.storeWe) begin
        dirtyQ[bus.hitWay][bus.lookupIndex] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (bus.fillWe) begin
      tagMem[bus.victimWay][bus.lookupIndex] <= reqTag;
    end
  end

  // compare both ways against the latched tag
  always_comb begin
    for (int w = 0; w < 2; w++) begin
      wayHit[w] = validQ[w][rdIdx] && (tagMem[w][rdIdx] == reqTag);
    end
  end

  assign bus.hit = |wayHit;
  assign bus.hitWay = wayHit[1];

  // only a valid line can need a write-back
  assign bus.victimDirty = validQ[bus.victimWay][rdIdx] && dirtyQ[bus.victimWay][rdIdx];
  assign bus.victimTag = tagMem[bus.victimWay][rdIdx];

endmodule

// ==== rtl/dataStore.sv ====
`timescale 1ns/1ps

module dataStore #(
  parameter int NUM_SETS = 64
) (
  input  logic clk,
  cacheCtrlIf.data bus
);

  localparam int IDX_W = $clog2(NUM_SETS);
  localparam int WORD_SEL_W = $clog2(dcachePkg::WORDS_PER_LINE);
  localparam int BYTE_SEL_W = $clog2(dcachePkg::WORD_BYTES);

  dcachePkg::line_t ways [2][NUM_SETS];
  dcachePkg::line_t lineQ [2];
  dcachePkg::line_t wrLine;
  dcachePkg::line_t storeLine;
  dcachePkg::word_t storeWord;
  dcachePkg::mask_t storeMask;
  logic [dcachePkg::LINE_BYTES-1:0] storeBe;
  logic [dcachePkg::LINE_BYTES-1:0] lineBe;
  logic [1:0] wayWe;
  logic [IDX_W-1:0] rdIdx;
  logic [WORD_SEL_W-1:0] wordSel;
  logic [BYTE_SEL_W-1:0] byteSel;

  assign wordSel = bus.reqAddr[dcachePkg::OFFSET_W-1 -: WORD_SEL_W];
  assign byteSel = bus.reqAddr[BYTE_SEL_W-1:0];

  // align the store to its byte lanes, then to its word in the line
  assign storeWord = bus.wrData << {byteSel, 3'b000};
  assign storeMask = bus.wrMask << byteSel;
  assign storeLine = {dcachePkg::WORDS_PER_LINE{storeWord}};
  assign storeBe = {{(dcachePkg::LINE_BYTES - dcachePkg::WORD_BYTES){1'b0}}, storeMask}
                   << (wordSel * dcachePkg::WORD_BYTES);

  // refill writes the whole line, a store hit only its bytes
  assign lineBe = bus.fillWe ? '1 : storeBe;

  always_comb begin
    for (int b = 0; b < dcachePkg::LINE_BYTES; b++) begin
      if (bus.reqWrite && storeBe[b]) begin
        wrLine[b*8 +: 8] = storeLine[b*8 +: 8];
      end else begin
        wrLine[b*8 +: 8] = bus.fillLine[b*8 +: 8];
      end
    end
  end

  always_comb begin
    wayWe = '0;
    if (bus.fillWe) begin
      wayWe[bus.victimWay] = 1'b1;
    end else if (bus.storeWe) begin
      wayWe[bus.hitWay] = 1'b1;
    end
  end

  // byte-masked line RAM, one per way
  always_ff @(posedge clk) begin
    for (int w = 0; w < 2; w++) begin
      for (int b = 0; b < dcachePkg::LINE_BYTES; b++) begin
        if (wayWe[w] && lineBe[b]) begin
          ways[w][bus.lookupIndex][b*8 +: 8] <= wrLine[b*8 +: 8];
        end
      end
    end
    if (bus.lookupEn) begin
      rdIdx <= bus.lookupIndex;
    end
  end

  // read through the registered index, so a fill is visible next cycle
  assign lineQ[0] = ways[0][rdIdx];
  assign lineQ[1] = ways[1][rdIdx];

  assign bus.rdWord = lineQ[bus.hitWay][wordSel*dcachePkg::XLEN +: dcachePkg::XLEN];
  assign bus.victimLine = lineQ[bus.victimWay];

endmodule

// ==== rtl/refillBuffer.sv ====
`timescale 1ns/1ps

module refillBuffer (
  input  logic clk,
  input  logic rst_n,
  input  logic dataValid_i,
  input  dcachePkg::word_t rdBeat_i,
  cacheCtrlIf.refill bus
);

  localparam int CNT_W = $clog2(dcachePkg::WORDS_PER_LINE);

  logic [CNT_W-1:0] beatCnt;
  logic beatTake;
  dcachePkg::line_t lineQ;

  assign beatTake = bus.beatEn && dataValid_i;

  // wraps to zero after the last beat of a line
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      beatCnt <= '0;
    end else if (beatTake) begin
      beatCnt <= beatCnt + 1'b1;
    end
  end

  // beats arrive in ascending word order
  always_ff @(posedge clk) begin
    if (beatTake) begin
      lineQ[beatCnt*dcachePkg::XLEN +: dcachePkg::XLEN] <= rdBeat_i;
    end
  end

  assign bus.fillLine = lineQ;

endmodule

// ==== rtl/dcacheTop.sv ====
`timescale 1ns/1ps

module dcacheTop #(
  parameter int NUM_SETS = 64
) (
  input  logic clk,
  input  logic rst_n,
  // request side
  input  logic reqValid_i,
  input  logic reqWrite_i,
  input  logic [dcachePkg::ADDR_W-1:0] addr_i,
  input  dcachePkg::word_t wrData_i,
  input  dcachePkg::mask_t wrMask_i,
  output logic addrOk_o,
  output logic dataOk_o,
  output dcachePkg::word_t rdData_o,
  // memory side
  output logic rdValid_o,
  output logic wrValid_o,
  output logic [dcachePkg::ADDR_W-1:0] rdAddr_o,
  output logic [dcachePkg::ADDR_W-1:0] wrAddr_o,
  input  logic rdReady_i,
  input  logic wrReady_i,
  input  logic dataValid_i,
  input  logic rdLast_i,
  input  dcachePkg::word_t rdBeat_i,
  output dcachePkg::line_t wrLine_o
);

  cacheCtrlIf #(.NUM_SETS(NUM_SETS)) ctrlBus ();

  cacheCtrl #(.NUM_SETS(NUM_SETS)) uCtrl (
    .clk(clk),
    .rst_n(rst_n),
    .reqValid_i(reqValid_i),
    .reqWrite_i(reqWrite_i),
    .addr_i(addr_i),
    .wrData_i(wrData_i),
    .wrMask_i(wrMask_i),
    .rdValid_o(rdValid_o),
    .rdAddr_o(rdAddr_o),
    .rdReady_i(rdReady_i),
    .rdLast_i(rdLast_i),
    .wrValid_o(wrValid_o),
    .wrAddr_o(wrAddr_o),
    .wrReady_i(wrReady_i),
    .dataValid_i(dataValid_i),
    .addrOk_o(addrOk_o),
    .dataOk_o(dataOk_o),
    .bus(ctrlBus.ctrl)
  );

  tagStore #(.NUM_SETS(NUM_SETS)) uTag (
    .clk(clk),
    .rst_n(rst_n),
    .bus(ctrlBus.tag)
  );

  dataStore #(.NUM_SETS(NUM_SETS)) uData (
    .clk(clk),
    .bus(ctrlBus.data)
  );

  refillBuffer uRefill (
    .clk(clk),
    .rst_n(rst_n),
    .dataValid_i(dataValid_i),
    .rdBeat_i(rdBeat_i),
    .bus(ctrlBus.refill)
  );

  // load word and write-back line straight from the data arrays
  assign rdData_o = ctrlBus.rdWord;
  assign wrLine_o = ctrlBus.victimLine;

endmodule

// ==== testbench/memModel.sv ====
`timescale 1ns/1ps

module memModel #(
  parameter int MEM_WORDS = 2048
) (
  input  logic clk,
  input  logic hold_i,
  input  logic rdValid_i,
  input  logic [dcachePkg::ADDR_W-1:0] rdAddr_i,
  output logic rdReady_o,
  output logic dataValid_o,
  output logic rdLast_o,
  output dcachePkg::word_t rdBeat_o,
  input  logic wrValid_i,
  input  logic [dcachePkg::ADDR_W-1:0] wrAddr_i,
  input  dcachePkg::line_t wrLine_i,
  output logic wrReady_o
);

  localparam int WIDX_W = $clog2(MEM_WORDS);

  dcachePkg::word_t mem [MEM_WORDS];
  logic [WIDX_W-1:0] base;
  integer seed;
  int gap;

  // unwritten words read as a pattern of their byte address
  function automatic dcachePkg::word_t fillWord(input logic [31:0] a);
    return {a ^ 32'hA5A5_5A5A, ~a};
  endfunction

  initial begin
    seed = 12;
    rdReady_o = 1'b0;
    wrReady_o = 1'b0;
    dataValid_o = 1'b0;
    rdLast_o = 1'b0;
    rdBeat_o = '0;
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem[i] = fillWord(i * 8);
    end
    forever begin
      @(posedge clk);
      #1;
      if (!hold_i && (rdValid_i || wrValid_i)) begin
        gap = $unsigned($random(seed)) % 4;
        repeat (gap) begin
          @(posedge clk);
          #1;
        end
        if (wrValid_i) begin
          // take the whole victim line while ready is high
          base = wrAddr_i[WIDX_W+2:3];
          for (int k = 0; k < dcachePkg::WORDS_PER_LINE; k++) begin
            mem[base + WIDX_W'(k)] = wrLine_i[k*64 +: 64];
          end
          wrReady_o = 1'b1;
          @(posedge clk);
          #1;
          wrReady_o = 1'b0;
        end else begin
          base = rdAddr_i[WIDX_W+2:3];
          rdReady_o = 1'b1;
          @(posedge clk);
          #1;
          rdReady_o = 1'b0;
          // four beats back to back, the last one flagged
          for (int k = 0; k < dcachePkg::WORDS_PER_LINE; k++) begin
            rdBeat_o = mem[base + WIDX_W'(k)];
            dataValid_o = 1'b1;
            rdLast_o = (k == dcachePkg::WORDS_PER_LINE - 1);
            @(posedge clk);
            #1;
          end
          dataValid_o = 1'b0;
          rdLast_o = 1'b0;
        end
      end
    end
  end

endmodule

// ==== testbench/tbDcache.sv ====
`timescale 1ns/1ps

module tbDcache;

  localparam int NUM_SETS = 64;
  localparam int TAG_LSB = dcachePkg::OFFSET_W + $clog2(NUM_SETS);
  localparam int MEM_BYTES = 16384;
  localparam int TIMEOUT = 200;

  logic clk;
  logic rst_n;
  logic reqValid, reqWrite, addrOk, dataOk;
  logic [dcachePkg::ADDR_W-1:0] addr, rdAddr, wrAddr;
  dcachePkg::word_t wrData, rdData, rdBeat;
  dcachePkg::mask_t wrMask;
  logic rdValid, rdReady, wrValid, wrReady, dataValid, rdLast;
  dcachePkg::line_t wrLine;
  logic holdMem;

  // program view of memory, one entry per byte
  logic [7:0] refMem [MEM_BYTES];
  int errors, checks, tests, wbCount, refillCount;
  integer seed;

  always #50 clk = ~clk;

  dcacheTop #(.NUM_SETS(NUM_SETS)) u_dut (
    .clk(clk), .rst_n(rst_n),
    .reqValid_i(reqValid), .reqWrite_i(reqWrite), .addr_i(addr),
    .wrData_i(wrData), .wrMask_i(wrMask),
    .addrOk_o(addrOk), .dataOk_o(dataOk), .rdData_o(rdData),
    .rdValid_o(rdValid), .wrValid_o(wrValid), .rdAddr_o(rdAddr), .wrAddr_o(wrAddr),
    .rdReady_i(rdReady), .wrReady_i(wrReady), .dataValid_i(dataValid),
    .rdLast_i(rdLast), .rdBeat_i(rdBeat), .wrLine_o(wrLine)
  );

  memModel #(.MEM_WORDS(MEM_BYTES / 8)) u_mem (
    .clk(clk), .hold_i(holdMem),
    .rdValid_i(rdValid), .rdAddr_i(rdAddr), .rdReady_o(rdReady),
    .dataValid_o(dataValid), .rdLast_o(rdLast), .rdBeat_o(rdBeat),
    .wrValid_i(wrValid), .wrAddr_i(wrAddr), .wrLine_i(wrLine), .wrReady_o(wrReady)
  );

  // same fill pattern as the backing memory
  function automatic dcachePkg::word_t initWord(input logic [31:0] a);
    return {a ^ 32'hA5A5_5A5A, ~a};
  endfunction

  function automatic dcachePkg::word_t modelWord(input logic [31:0] a);
    dcachePkg::word_t w;
    for (int b = 0; b < 8; b++) begin
      w[b*8 +: 8] = refMem[{a[13:3], 3'b000} + 14'(b)];
    end
    return w;
  endfunction

  function automatic dcachePkg::line_t modelLine(input logic [31:0] a);
    dcachePkg::line_t l;
    for (int b = 0; b < 32; b++) begin
      l[b*8 +: 8] = refMem[{a[13:5], 5'b00000} + 14'(b)];
    end
    return l;
  endfunction

  function automatic void modelStore(input logic [31:0] a, input dcachePkg::word_t d,
                                     input dcachePkg::mask_t m);
    for (int b = 0; b < 8; b++) begin
      if (m[b]) begin
        refMem[{a[13:3], 3'b000} + 14'(b)] = d[b*8 +: 8];
      end
    end
  endfunction

  function automatic logic [63:0] expandMask(input dcachePkg::mask_t m);
    logic [63:0] e;
    for (int b = 0; b < 8; b++) begin
      e[b*8 +: 8] = {8{m[b]}};
    end
    return e;
  endfunction

  function automatic logic [31:0] lineAddr(input int tag, input int set, input int word);
    return (tag << TAG_LSB) | (set << dcachePkg::OFFSET_W) | (word << 3);
  endfunction

  function automatic dcachePkg::word_t randWord();
    return {$random(seed), $random(seed)};
  endfunction

  task automatic expectWord(input string sig, input logic [63:0] got, input logic [63:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("mismatch %s: got %h expected %h", sig, got, exp);
      errors++;
    end
  endtask

  task automatic expectTrue(input logic ok, input string what);
    checks++;
    assert (ok) else begin
      $display("error: %s", what);
      errors++;
    end
  endtask

  task automatic tick();
    @(posedge clk);
    #1;
  endtask

  // hold the request until an edge with addrOk high takes it
  task automatic issue(input logic wr, input logic [31:0] a, input dcachePkg::word_t d,
                       input dcachePkg::mask_t m);
    int n;
    reqValid = 1'b1;
    reqWrite = wr;
    addr = a;
    wrData = d;
    wrMask = m;
    n = 0;
    @(negedge clk);
    while (!addrOk && n < TIMEOUT) begin
      n++;
      @(negedge clk);
    end
    expectTrue(addrOk, "request was not accepted before the timeout");
    tick();
    reqValid = 1'b0;
  endtask

  // cycles counts from the acceptance edge to the dataOk cycle
  task automatic waitDone(output dcachePkg::word_t rd, output int cycles);
    cycles = 1;
    @(negedge clk);
    while (!dataOk && cycles < TIMEOUT) begin
      cycles++;
      @(negedge clk);
    end
    expectTrue(dataOk, "timed out waiting for dataOk_o");
    rd = rdData;
    tick();
  endtask

  task automatic loadCheck(input logic [31:0] a, output int cycles);
    dcachePkg::word_t rd;
    issue(1'b0, a, '0, '0);
    waitDone(rd, cycles);
    expectWord("rdData_o", rd, modelWord(a));
  endtask

  task automatic writeWord(input logic [31:0] a, input dcachePkg::word_t d,
                           input dcachePkg::mask_t m);
    dcachePkg::word_t rd;
    int cycles;
    issue(1'b1, a, d, m);
    waitDone(rd, cycles);
    modelStore(a, d, m);
  endtask

  task automatic reportTest(input string name, input int errBefore);
    tests++;
    $display("test %0d %s: %0d errors", tests, name, errors - errBefore);
  endtask

  // every write-back must carry the line as the program last wrote it
  always @(negedge clk) begin
    if (rst_n && wrValid && wrReady) begin
      wbCount++;
      expectTrue(wrAddr[4:0] == '0, "write-back address is not line aligned");
      checks++;
      assert (wrLine === modelLine(wrAddr)) else begin
        $display("mismatch wrLine_o at %h: got %h expected %h", wrAddr, wrLine,
                 modelLine(wrAddr));
        errors++;
      end
    end
    if (rst_n && rdValid && rdReady) begin
      refillCount++;
      expectTrue(rdAddr[4:0] == '0, "refill address is not line aligned");
    end
  end

  initial begin
    dcachePkg::word_t w, d, old, rd;
    dcachePkg::mask_t m;
    logic [31:0] a, heldAddr;
    logic heldWr;
    int cyc, errBefore, cntBefore, n;
    clk = 1'b0;
    rst_n = 1'b0;
    reqValid = 1'b0;
    reqWrite = 1'b0;
    addr = '0;
    wrData = '0;
    wrMask = '0;
    holdMem = 1'b0;
    seed = 12;
    errors = 0;
    checks = 0;
    tests = 0;
    wbCount = 0;
    refillCount = 0;
    for (int i = 0; i < MEM_BYTES / 8; i++) begin
      w = initWord(i * 8);
      for (int b = 0; b < 8; b++) begin
        refMem[i*8 + b] = w[b*8 +: 8];
      end
    end
    repeat (8) @(posedge clk);
    #1;
    rst_n = 1'b1;

    errBefore = errors;
    @(negedge clk);
    expectTrue(addrOk && !dataOk && !rdValid && !wrValid, "outputs not idle after reset");
    tick();
    a = lineAddr(0, 0, 1);
    issue(1'b0, a, '0, '0);
    waitDone(rd, cyc);
    expectWord("rdData_o", rd, initWord(a));
    reportTest("reset and first load", errBefore);

    // first store misses, the second hits the filled line
    errBefore = errors;
    for (int k = 0; k < 2; k++) begin
      a = lineAddr(0, 1, 2 + k);
      d = randWord();
      m = 8'($random(seed));
      old = modelWord(a);
      writeWord(a, d, m);
      issue(1'b0, a, '0, '0);
      waitDone(rd, cyc);
      expectWord("rdData_o", rd, (old & ~expandMask(m)) | (d & expandMask(m)));
    end
    reportTest("store then load", errBefore);

    // five dirty lines through two ways of set 3
    errBefore = errors;
    cntBefore = wbCount;
    for (int t = 0; t < 5; t++) begin
      writeWord(lineAddr(t, 3, t % 4), randWord(), 8'hFF);
    end
    expectWord("write-back count", 64'(wbCount - cntBefore), 64'd3);
    for (int t = 0; t < 5; t++) begin
      loadCheck(lineAddr(t, 3, t % 4), cyc);
    end
    reportTest("dirty eviction", errBefore);

    errBefore = errors;
    loadCheck(lineAddr(5, 7, 0), cyc);
    cntBefore = refillCount;
    for (int k = 0; k < 4; k++) begin
      loadCheck(lineAddr(5, 7, k), cyc);
      expectWord("dataOk_o latency", 64'(cyc), 64'd1);
    end
    expectTrue(refillCount == cntBefore, "a load to a filled line started a refill");
    reportTest("hit latency", errBefore);

    // memory held off, the request must wait with a stable address
    errBefore = errors;
    holdMem = 1'b1;
    a = lineAddr(6, 3, 1);
    issue(1'b0, a, '0, '0);
    n = 0;
    @(negedge clk);
    while (!(rdValid || wrValid) && n < TIMEOUT) begin
      n++;
      @(negedge clk);
    end
    expectTrue(rdValid || wrValid, "no memory request after a miss");
    heldWr = wrValid;
    heldAddr = wrValid ? wrAddr : rdAddr;
    repeat (20) begin
      @(negedge clk);
      expectTrue(heldWr ? wrValid : rdValid, "memory request dropped while not ready");
      expectWord(heldWr ? "wrAddr_o" : "rdAddr_o", heldWr ? wrAddr : rdAddr, heldAddr);
      expectTrue(!dataOk, "dataOk_o rose while the memory bus was held");
    end
    holdMem = 1'b0;
    waitDone(rd, cyc);
    expectWord("rdData_o", rd, modelWord(a));
    reportTest("back-pressure", errBefore);

    errBefore = errors;
    for (int i = 0; i < 2000; i++) begin
      a = lineAddr($unsigned($random(seed)) % 4, $unsigned($random(seed)) % 8,
                   $unsigned($random(seed)) % 4);
      if ($random(seed) & 1) begin
        writeWord(a, randWord(), 8'($random(seed)));
      end else begin
        loadCheck(a, cyc);
      end
    end
    reportTest("random mix", errBefore);

    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

// ==== src.f ====
rtl/dcachePkg.sv
rtl/cacheCtrlIf.sv
rtl/cacheCtrl.sv
rtl/tagStore.sv
rtl/dataStore.sv
rtl/refillBuffer.sv
rtl/dcacheTop.sv
testbench/memModel.sv
testbench/tbDcache.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= tbDcache
FILELIST ?= src.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	$(BUILD_DIR)/$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -qx "Test OK" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
